/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = mem_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir
RUN_ARGS = +verilator+error+limit+1000
LOG      = sim.log

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/mem_arb.sv */
// round-robin credit arbiter that puts one client at a time on the LTC port and routes reads back
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_arb
	import mem_ltc_pkg::*, mem_arb_pkg::*;
(
	input  logic                                     clkrst_mem_clk,
	input  logic                                     clkrst_mem_rst_n,

	input  logic [`MEM_CLIENTS-1:0]                  cli_valid,
	input  logic [`MEM_CLIENTS*`MEM_OPC_BITS-1:0]    cli_opcode,
	input  logic [`MEM_CLIENTS*`MEM_ADDR_BITS-1:0]   cli_addr,
	input  logic [`MEM_CLIENTS*`MEM_LINE_BITS-1:0]   cli_wdata,
	input  logic [`MEM_CLIENTS*`MEM_LINE_BYTES-1:0]  cli_wbe,
	output logic [`MEM_CLIENTS-1:0]                  cli_stall,
	output logic [`MEM_LINE_BITS-1:0]                cli_rdata,
	output logic [`MEM_CLIENTS-1:0]                  cli_rvalid,

	output logic                                     ltc_valid,
	output ltc_opcode_t                              ltc_opcode,
	output ltc_line_addr_u                           ltc_addr,
	output logic [`MEM_LINE_BITS-1:0]                ltc_wdata,
	output logic [`MEM_LINE_BYTES-1:0]               ltc_wbe,
	input  logic                                     ltc_stall,
	input  logic [`MEM_LINE_BITS-1:0]                ltc_rdata,
	input  logic                                     ltc_rvalid
);

	// one spare bit so the rotated sum can be wrapped back into range
	localparam int next_bits = `MEM_CLIENT_BITS + 1;

	arb_client_t                  cur_client;
	arb_credit_t                  credits_left;
	logic [2*`MEM_CLIENTS-1:0]    valid_dbl;
	logic [`MEM_CLIENTS-1:0]      valid_rot;
	logic [next_bits-1:0]         next_wide;
	arb_client_t                  next_client;

	logic                         sel_valid;
	logic                         sel_has_rdata;
	logic                         rdfifo_push;
	logic                         rdfifo_full;
	arb_client_t                  rdfifo_rdata;
	logic                         rdfifo_empty;
	logic                         rdfifo_wait;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next client selection
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// rotate the valids so that bit 0 is the current grant holder
	assign valid_dbl = {cli_valid, cli_valid} >> cur_client;
	assign valid_rot = valid_dbl[`MEM_CLIENTS-1:0];

	// the closest valid client after the holder wins, otherwise the grant stays put
	always_comb begin
		next_wide = {1'b0, cur_client};
		for (int i = `MEM_CLIENTS - 1; i > 0; i--) begin
			if (valid_rot[i])
				next_wide = {1'b0, cur_client} + next_bits'(i);
		end
		if (next_wide >= next_bits'(`MEM_CLIENTS))
			next_wide = next_wide - next_bits'(`MEM_CLIENTS);
	end

	assign next_client = next_wide[`MEM_CLIENT_BITS-1:0];

	// the grant only moves on an unstalled edge, so the LTC never sees the
	// request change under a stall
	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			cur_client   <= '0;
			credits_left <= arb_credit_t'(`MEM_CREDITS_DEFAULT);
		end else if (!ltc_stall) begin
			if (credits_left == '0 || !sel_valid) begin
				cur_client   <= next_client;
				credits_left <= arb_credit_t'(`MEM_CREDITS_DEFAULT);
			end else if (ltc_valid) begin
				// credits count accepted requests, not cycles
				credits_left <= credits_left - 1'b1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// granted lane onto the LTC port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sel_valid  = cli_valid[cur_client];
	assign ltc_opcode = ltc_opcode_t'(cli_opcode[cur_client*`MEM_OPC_BITS +: `MEM_OPC_BITS]);
	assign ltc_addr.line = cli_addr[cur_client*`MEM_ADDR_BITS +: `MEM_ADDR_BITS];
	assign ltc_wdata  = cli_wdata[cur_client*`MEM_LINE_BITS +: `MEM_LINE_BITS];
	assign ltc_wbe    = cli_wbe[cur_client*`MEM_LINE_BYTES +: `MEM_LINE_BYTES];

	assign sel_has_rdata = ltc_has_rdata(ltc_opcode);

	// a read with no room left to record its client waits here
	assign rdfifo_wait = sel_valid && sel_has_rdata && rdfifo_full;
	assign ltc_valid   = sel_valid && !rdfifo_wait;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read routing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the LTC answers in order, so the FIFO head names the owner of each result
	assign rdfifo_push = ltc_valid && !ltc_stall && sel_has_rdata;

	mem_fifo #(
		.depth(`MEM_RDFIFO_DEPTH),
		.width(`MEM_CLIENT_BITS)
	) u_rdfifo (
		.clkrst_mem_clk  (clkrst_mem_clk),
		.clkrst_mem_rst_n(clkrst_mem_rst_n),
		.push            (rdfifo_push),
		.wdata           (cur_client),
		.full            (rdfifo_full),
		.pop             (ltc_rvalid),
		.rdata           (rdfifo_rdata),
		.empty           (rdfifo_empty)
	);

	// every client sees the same data bus, only its rvalid bit says it is meant for it
	assign cli_rdata = ltc_rdata;

	always_comb begin
		for (int c = 0; c < `MEM_CLIENTS; c++) begin
			cli_stall[c]  = cli_valid[c] &&
				(cur_client != arb_client_t'(c) || ltc_stall || rdfifo_wait);
			cli_rvalid[c] = ltc_rvalid && !rdfifo_empty && rdfifo_rdata == arb_client_t'(c);
		end
	end

endmodule

/* hw/mem_arb_pkg.sv */
// arbiter-side types for client numbers and credit counts, imported by the arbiter and its checks
`include "mem_defs.svh"

package mem_arb_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// grant bookkeeping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// index of one client lane, also what the read FIFO stores
	typedef logic [`MEM_CLIENT_BITS-1:0] arb_client_t;

	// requests the grant holder may still issue before the grant moves
	typedef logic [`MEM_CREDIT_BITS-1:0] arb_credit_t;

endpackage

/* hw/mem_fifo.sv */
// small synchronous FIFO, used by the arbiter to remember which client each read belongs to
`timescale 1ns/1ns

module mem_fifo #(
	parameter int depth = 2,
	parameter int width = 1
) (
	input  logic             clkrst_mem_clk,
	input  logic             clkrst_mem_rst_n,
	input  logic             push,
	input  logic [width-1:0] wdata,
	output logic             full,
	input  logic             pop,
	output logic [width-1:0] rdata,
	output logic             empty
);

	localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_bits = $clog2(depth + 1);

	logic [width-1:0]    mem [depth];
	logic [ptr_bits-1:0] rd_ptr;
	logic [ptr_bits-1:0] wr_ptr;
	logic [cnt_bits-1:0] count;
	logic                do_push;
	logic                do_pop;

	// a push into a full FIFO or a pop from an empty one is ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full  = count == cnt_bits'(depth);
	assign empty = count == '0;
	assign rdata = mem[rd_ptr];

	always_ff @(posedge clkrst_mem_clk) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			// both at once leaves the occupancy unchanged
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

/* hw/mem_ltc.sv */
// fixed-latency line-store model of the last-level cache port, driven by the arbiter
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_ltc
	import mem_ltc_pkg::*;
(
	input  logic                        clkrst_mem_clk,
	input  logic                        clkrst_mem_rst_n,

	input  logic                        ltc_valid,
	input  ltc_opcode_t                 ltc_opcode,
	input  ltc_line_addr_u              ltc_addr,
	input  logic [`MEM_LINE_BITS-1:0]   ltc_wdata,
	input  logic [`MEM_LINE_BYTES-1:0]  ltc_wbe,
	output logic                        ltc_stall,
	output logic [`MEM_LINE_BITS-1:0]   ltc_rdata,
	output logic                        ltc_rvalid
);

	localparam int n_lines = 1 << `MEM_LTC_SET_BITS;

	logic [`MEM_LINE_BITS-1:0]   store [n_lines];

	logic                        accept;
	logic                        acc_read;
	logic                        acc_write;

	logic                        s1_valid;
	logic [`MEM_LTC_SET_BITS-1:0] s1_set;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// request decode
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// NOP and PREFETCH are accepted like anything else but leave no trace
	assign accept    = ltc_valid && !ltc_stall;
	assign acc_read  = accept && ltc_has_rdata(ltc_opcode);
	assign acc_write = accept && ltc_is_write(ltc_opcode);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// store and read pipeline
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// only the set index picks a line here, the tag has no part in this model
	always_ff @(posedge clkrst_mem_clk) begin
		if (acc_write) begin
			for (int b = 0; b < `MEM_LINE_BYTES; b++) begin
				if (ltc_wbe[b])
					store[ltc_addr.idx.set][b*8 +: 8] <= ltc_wdata[b*8 +: 8];
			end
		end
	end

	// stage 1 latches the set of an accepted read, stage 2 fetches the line
	// a write accepted in the same edge as the fetch lands afterwards, which
	// keeps results in acceptance order
	always_ff @(posedge clkrst_mem_clk) begin
		if (acc_read)
			s1_set <= ltc_addr.idx.set;
		if (s1_valid)
			ltc_rdata <= store[s1_set];
	end

	// rvalid is set one edge after acceptance, so it is seen at the second
	// edge after the one that took the read
	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			s1_valid   <= 1'b0;
			ltc_rvalid <= 1'b0;
		end else begin
			s1_valid   <= acc_read;
			ltc_rvalid <= s1_valid;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write bubble
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one stalled cycle after every accepted write, never two in a row since
	// nothing is accepted while stalled
	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n)
			ltc_stall <= 1'b0;
		else
			ltc_stall <= acc_write;
	end

endmodule

/* hw/mem_ltc_pkg.sv */
// command-side types of the LTC port, imported by the arbiter, the LTC model and the checks
`include "mem_defs.svh"

package mem_ltc_pkg;

	typedef enum logic [`MEM_OPC_BITS-1:0] {
		LTC_OPC_NOP          = 3'd0,
		LTC_OPC_READ         = 3'd1,
		LTC_OPC_READTHROUGH  = 3'd2,
		LTC_OPC_WRITE        = 3'd3,
		LTC_OPC_WRITETHROUGH = 3'd4,
		LTC_OPC_PREFETCH     = 3'd5
	} ltc_opcode_t;

	// one 32-byte line address, bits 31 down to 5 of the byte address
	typedef union packed {
		logic [`MEM_ADDR_BITS-1:0] line;
		struct packed {
			logic [`MEM_ADDR_BITS-`MEM_LTC_SET_BITS-1:0] tag;
			logic [`MEM_LTC_SET_BITS-1:0] set;
		} idx;
	} ltc_line_addr_u;

	function automatic logic ltc_has_rdata(ltc_opcode_t op);
		return op == LTC_OPC_READ || op == LTC_OPC_READTHROUGH;
	endfunction

	function automatic logic ltc_is_write(ltc_opcode_t op);
		return op == LTC_OPC_WRITE || op == LTC_OPC_WRITETHROUGH;
	endfunction

endpackage

/* hw/mem_top.sv */
// top level of the memory subsystem, clients on one side and the LTC model behind the arbiter
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_top
	import mem_ltc_pkg::*;
(
	input  logic                                     clkrst_mem_clk,
	input  logic                                     clkrst_mem_rst_n,

	input  logic [`MEM_CLIENTS-1:0]                  cli_valid,
	input  logic [`MEM_CLIENTS*`MEM_OPC_BITS-1:0]    cli_opcode,
	input  logic [`MEM_CLIENTS*`MEM_ADDR_BITS-1:0]   cli_addr,
	input  logic [`MEM_CLIENTS*`MEM_LINE_BITS-1:0]   cli_wdata,
	input  logic [`MEM_CLIENTS*`MEM_LINE_BYTES-1:0]  cli_wbe,
	output logic [`MEM_CLIENTS-1:0]                  cli_stall,
	output logic [`MEM_LINE_BITS-1:0]                cli_rdata,
	output logic [`MEM_CLIENTS-1:0]                  cli_rvalid
);

	// arbiter to LTC port
	logic                        ltc_valid;
	ltc_opcode_t                 ltc_opcode;
	ltc_line_addr_u              ltc_addr;
	logic [`MEM_LINE_BITS-1:0]   ltc_wdata;
	logic [`MEM_LINE_BYTES-1:0]  ltc_wbe;
	logic                        ltc_stall;
	logic [`MEM_LINE_BITS-1:0]   ltc_rdata;
	logic                        ltc_rvalid;

	mem_arb u_arb (
		.clkrst_mem_clk  (clkrst_mem_clk),
		.clkrst_mem_rst_n(clkrst_mem_rst_n),
		.cli_valid       (cli_valid),
		.cli_opcode      (cli_opcode),
		.cli_addr        (cli_addr),
		.cli_wdata       (cli_wdata),
		.cli_wbe         (cli_wbe),
		.cli_stall       (cli_stall),
		.cli_rdata       (cli_rdata),
		.cli_rvalid      (cli_rvalid),
		.ltc_valid       (ltc_valid),
		.ltc_opcode      (ltc_opcode),
		.ltc_addr        (ltc_addr),
		.ltc_wdata       (ltc_wdata),
		.ltc_wbe         (ltc_wbe),
		.ltc_stall       (ltc_stall),
		.ltc_rdata       (ltc_rdata),
		.ltc_rvalid      (ltc_rvalid)
	);

	mem_ltc u_ltc (
		.clkrst_mem_clk  (clkrst_mem_clk),
		.clkrst_mem_rst_n(clkrst_mem_rst_n),
		.ltc_valid       (ltc_valid),
		.ltc_opcode      (ltc_opcode),
		.ltc_addr        (ltc_addr),
		.ltc_wdata       (ltc_wdata),
		.ltc_wbe         (ltc_wbe),
		.ltc_stall       (ltc_stall),
		.ltc_rdata       (ltc_rdata),
		.ltc_rvalid      (ltc_rvalid)
	);

endmodule

/* include/mem_defs.svh */
// sizing macros shared by the memory subsystem, include wherever a count or a width is needed
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// client side of the arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MEM_CLIENTS 2
`define MEM_CLIENT_BITS 1

// every client restarts with this many extra requests after a grant
`define MEM_CREDITS_DEFAULT 1
`define MEM_CREDIT_BITS 3

// reads in flight between the arbiter and the LTC
`define MEM_RDFIFO_DEPTH 2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LTC port and line store
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define MEM_OPC_BITS 3
`define MEM_ADDR_BITS 27
`define MEM_LINE_BITS 256
`define MEM_LINE_BYTES 32

// index bits of the line store, 16 lines
`define MEM_LTC_SET_BITS 4

`endif

/* sim.f */
+incdir+include
hw/mem_ltc_pkg.sv
hw/mem_arb_pkg.sv
hw/mem_fifo.sv
hw/mem_arb.sv
hw/mem_ltc.sv
hw/mem_top.sv
test/mem_tb_chk.sv
test/mem_tb.sv

/* test/mem_tb.sv */
// testbench for the memory subsystem, runs fill, random and read-burst traffic from both clients
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_tb
	import mem_ltc_pkg::*;
();

	localparam int n_lines     = 1 << `MEM_LTC_SET_BITS;
	localparam int n_random    = 300;
	localparam int n_burst     = 12;
	localparam int cycle_limit = 4 * (n_lines + n_random + n_burst) + 200;
	localparam int req_bits    = 1 + `MEM_OPC_BITS + `MEM_ADDR_BITS + `MEM_LINE_BITS
		+ `MEM_LINE_BYTES;

	logic                                     clkrst_mem_clk = 1'b0;
	logic                                     clkrst_mem_rst_n;
	logic [`MEM_CLIENTS-1:0]                  cli_valid;
	logic [`MEM_CLIENTS*`MEM_OPC_BITS-1:0]    cli_opcode;
	logic [`MEM_CLIENTS*`MEM_ADDR_BITS-1:0]   cli_addr;
	logic [`MEM_CLIENTS*`MEM_LINE_BITS-1:0]   cli_wdata;
	logic [`MEM_CLIENTS*`MEM_LINE_BYTES-1:0]  cli_wbe;
	logic [`MEM_CLIENTS-1:0]                  cli_stall;
	logic [`MEM_LINE_BITS-1:0]                cli_rdata;
	logic [`MEM_CLIENTS-1:0]                  cli_rvalid;

	// a queued request is {idle, opcode, line address, write data, byte enables}
	logic [req_bits-1:0]        pend_q [`MEM_CLIENTS][$];
	logic [`MEM_LINE_BITS-1:0]  exp_data [`MEM_CLIENTS][$];
	int unsigned                exp_due [`MEM_CLIENTS][$];
	logic [`MEM_LINE_BITS-1:0]  shadow [n_lines];
	logic [31:0]                rng_state = 32'h473080dc;
	int unsigned                cycles = 0;
	int unsigned                data_errors = 0;
	int unsigned                proto_errors = 0;
	int unsigned                reads_checked = 0;
	logic                       reset_window = 1'b0;
	logic                       bubble_due = 1'b0;

	mem_top DUT (
		.clkrst_mem_clk  (clkrst_mem_clk),
		.clkrst_mem_rst_n(clkrst_mem_rst_n),
		.cli_valid       (cli_valid),
		.cli_opcode      (cli_opcode),
		.cli_addr        (cli_addr),
		.cli_wdata       (cli_wdata),
		.cli_wbe         (cli_wbe),
		.cli_stall       (cli_stall),
		.cli_rdata       (cli_rdata),
		.cli_rvalid      (cli_rvalid)
	);

	always #10 clkrst_mem_clk = ~clkrst_mem_clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic logic [`MEM_LINE_BITS-1:0] random_line();
		logic [`MEM_LINE_BITS-1:0] line;
		for (int w = 0; w < `MEM_LINE_BITS / 32; w++)
			line[w*32 +: 32] = next_random();
		return line;
	endfunction

	// the set index sits in the low bits of the line address
	function automatic logic [`MEM_ADDR_BITS-1:0] random_addr(logic [`MEM_LTC_SET_BITS-1:0] set);
		logic [31:0] r;
		r = next_random();
		return {r[`MEM_ADDR_BITS-`MEM_LTC_SET_BITS-1:0], set};
	endfunction

	function automatic logic returns_data(logic [`MEM_OPC_BITS-1:0] op);
		return op == LTC_OPC_READ || op == LTC_OPC_READTHROUGH;
	endfunction

	function automatic logic is_write_op(logic [`MEM_OPC_BITS-1:0] op);
		return op == LTC_OPC_WRITE || op == LTC_OPC_WRITETHROUGH;
	endfunction

	task automatic queue_request(int c, logic [`MEM_OPC_BITS-1:0] op, logic [`MEM_LINE_BYTES-1:0] wbe);
		logic [`MEM_ADDR_BITS-1:0] addr;
		logic [`MEM_LINE_BITS-1:0] wdata;
		addr  = random_addr(next_random() % n_lines);
		wdata = random_line();
		pend_q[c].push_back({1'b0, op, addr, wdata, wbe});
	endtask

	task automatic load_fill();
		logic [`MEM_ADDR_BITS-1:0] addr;
		logic [`MEM_LINE_BITS-1:0] wdata;
		for (int i = 0; i < n_lines; i++) begin
			addr  = random_addr(i[`MEM_LTC_SET_BITS-1:0]);
			wdata = random_line();
			pend_q[i % 2].push_back({1'b0, LTC_OPC_WRITE, addr, wdata, {`MEM_LINE_BYTES{1'b1}}});
		end
	endtask

	// now and then a client drops valid for a cycle so the grant has to move
	task automatic load_random();
		logic [`MEM_OPC_BITS-1:0] op;
		for (int k = 0; k < n_random; k++) begin
			if (next_random() % 8 == 0)
				pend_q[k % 2].push_back({1'b1, {(req_bits - 1){1'b0}}});
			op = `MEM_OPC_BITS'(next_random() % 6);
			queue_request(k % 2, op, next_random());
		end
	endtask

	task automatic load_burst();
		for (int k = 0; k < n_burst; k++)
			queue_request(k % 2, LTC_OPC_READ, '0);
	endtask

	// the head of each queue stays on the port until the monitor sees it taken
	task automatic drive_inputs();
		logic [req_bits-1:0] req;
		for (int c = 0; c < `MEM_CLIENTS; c++) begin
			if (pend_q[c].size() != 0 && pend_q[c][0][req_bits-1]) begin
				void'(pend_q[c].pop_front());
				cli_valid[c] = 1'b0;
			end else if (pend_q[c].size() != 0) begin
				req = pend_q[c][0];
				cli_valid[c] = 1'b1;
				{cli_opcode[c*`MEM_OPC_BITS +: `MEM_OPC_BITS], cli_addr[c*`MEM_ADDR_BITS +: `MEM_ADDR_BITS],
					cli_wdata[c*`MEM_LINE_BITS +: `MEM_LINE_BITS],
					cli_wbe[c*`MEM_LINE_BYTES +: `MEM_LINE_BYTES]} = req[req_bits-2:0];
			end else begin
				cli_valid[c] = 1'b0;
			end
		end
	endtask

	function automatic logic all_idle();
		for (int c = 0; c < `MEM_CLIENTS; c++)
			if (pend_q[c].size() != 0 || exp_data[c].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic run_until_idle();
		do begin
			@(negedge clkrst_mem_clk);
			drive_inputs();
		end while (!all_idle());
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// monitor and line-store model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clkrst_mem_clk) begin
		logic [req_bits-1:0]        req;
		logic                       idle;
		logic [`MEM_OPC_BITS-1:0]   op;
		logic [`MEM_ADDR_BITS-1:0]  addr;
		logic [`MEM_LINE_BITS-1:0]  wdata;
		logic [`MEM_LINE_BYTES-1:0] wbe;
		logic                       bubble_next;
		bubble_next = 1'b0;
		if (clkrst_mem_rst_n) begin
			if (reset_window)
				assert (!DUT.ltc_valid && cli_stall == '0 && cli_rvalid == '0) else begin
					proto_errors++;
					$display("after reset a port signal was high with no client valid");
				end
			// the cycle after a write belongs to the LTC alone
			if (bubble_due)
				assert ((cli_valid & ~cli_stall) == '0) else begin
					proto_errors++;
					$display("a request was not stalled in the cycle after a write");
				end
			for (int c = 0; c < `MEM_CLIENTS; c++) begin
				if (cli_rvalid[c]) begin
					assert (exp_data[c].size() != 0) else begin
						proto_errors++;
						$display("client %0d got read data with no read outstanding", c);
					end
					if (exp_data[c].size() != 0) begin
						assert (exp_due[c][0] == cycles) else begin
							proto_errors++;
							$display("client %0d read came back at cycle %0d, due at %0d", c, cycles,
								exp_due[c][0]);
						end
						assert (cli_rdata === exp_data[c][0]) else begin
							data_errors++;
							$display("MISMATCH cli_rdata client %0d: got %h expected %h", c, cli_rdata,
								exp_data[c][0]);
						end
						reads_checked++;
						void'(exp_data[c].pop_front());
						void'(exp_due[c].pop_front());
					end
				end else if (exp_due[c].size() != 0) begin
					assert (exp_due[c][0] > cycles) else begin
						proto_errors++;
						$display("client %0d read due at cycle %0d never came back", c, exp_due[c][0]);
						void'(exp_data[c].pop_front());
						void'(exp_due[c].pop_front());
					end
				end
				if (cli_valid[c] && !cli_stall[c] && pend_q[c].size() != 0) begin
					req = pend_q[c].pop_front();
					{idle, op, addr, wdata, wbe} = req;
					if (is_write_op(op)) begin
						for (int b = 0; b < `MEM_LINE_BYTES; b++)
							if (wbe[b])
								shadow[addr[`MEM_LTC_SET_BITS-1:0]][b*8 +: 8] = wdata[b*8 +: 8];
						bubble_next = 1'b1;
					end
					if (returns_data(op)) begin
						exp_data[c].push_back(shadow[addr[`MEM_LTC_SET_BITS-1:0]]);
						exp_due[c].push_back(cycles + 2);
					end
				end
			end
			bubble_due = bubble_next;
		end
		cycles++;
	end

	initial begin
		while (cycles < cycle_limit)
			@(posedge clkrst_mem_clk);
		$display("timeout: traffic still pending after %0d cycles", cycles);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int unsigned total;
		cli_valid = '0;
		cli_opcode = '0;
		cli_addr = '0;
		cli_wdata = '0;
		cli_wbe = '0;
		clkrst_mem_rst_n = 1'b0;
		repeat (5) @(posedge clkrst_mem_clk);
		@(negedge clkrst_mem_clk);
		clkrst_mem_rst_n = 1'b1;
		reset_window = 1'b1;
		repeat (4) @(negedge clkrst_mem_clk);
		reset_window = 1'b0;
		load_fill();
		run_until_idle();
		load_random();
		run_until_idle();
		load_burst();
		run_until_idle();
		repeat (3) @(negedge clkrst_mem_clk);
		total = data_errors + proto_errors + DUT.u_arb.u_chk.fail_count;
		$display("reads checked %0d, data errors %0d, protocol errors %0d, assertion errors %0d",
			reads_checked, data_errors, proto_errors, DUT.u_arb.u_chk.fail_count);
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* test/mem_tb_chk.sv */
// protocol assertions on the arbiter, bound into mem_arb when the testbench is compiled
`timescale 1ns/1ns
`include "mem_defs.svh"

module mem_tb_chk
	import mem_ltc_pkg::*, mem_arb_pkg::*;
(
	input logic                    clkrst_mem_clk,
	input logic                    clkrst_mem_rst_n,
	input logic [`MEM_CLIENTS-1:0] cli_valid,
	input logic [`MEM_CLIENTS-1:0] cli_stall,
	input arb_client_t             cur_client,
	input logic                    ltc_valid,
	input ltc_opcode_t             ltc_opcode,
	input logic                    ltc_stall,
	input logic                    ltc_rvalid
);

	localparam logic [7:0] run_max   = 8'(`MEM_CREDITS_DEFAULT + 1);
	localparam logic [2:0] depth_max = 3'(`MEM_RDFIFO_DEPTH);

	int unsigned             fail_count = 0;
	logic [`MEM_CLIENTS-1:0] grant_mask;
	logic                    accept;
	logic                    push;
	logic                    others_valid;
	logic [7:0]              run_len;
	arb_client_t             run_client;
	logic [2:0]              outstanding;

	always_comb begin
		grant_mask = '0;
		grant_mask[cur_client] = 1'b1;
	end

	assign accept       = ltc_valid && !ltc_stall;
	assign push         = accept && ltc_has_rdata(ltc_opcode);
	assign others_valid = |(cli_valid & ~grant_mask);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// run length of one client and reads in flight
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// a run only counts while some other client is waiting for the port
	always_ff @(posedge clkrst_mem_clk or negedge clkrst_mem_rst_n) begin
		if (!clkrst_mem_rst_n) begin
			run_len     <= '0;
			run_client  <= '0;
			outstanding <= '0;
		end else begin
			if (accept) begin
				run_client <= cur_client;
				if (!others_valid)
					run_len <= '0;
				else if (run_len != '0 && run_client == cur_client)
					run_len <= run_len + 8'd1;
				else
					run_len <= 8'd1;
			end
			if (push && !ltc_rvalid)
				outstanding <= outstanding + 3'd1;
			else if (!push && ltc_rvalid && outstanding != '0)
				outstanding <= outstanding - 3'd1;
		end
	end

	// the holder gets its credits plus the request that spends the last one
	fair_run: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		run_len <= run_max)
	else begin
		fail_count++;
		$error("one client held the port too long while another was waiting");
	end

	stall_others: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		(cli_valid & ~grant_mask & ~cli_stall) == '0)
	else begin
		fail_count++;
		$error("a valid client without the grant was not stalled");
	end

	fifo_limit: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		outstanding <= depth_max)
	else begin
		fail_count++;
		$error("more reads in flight than the read FIFO can track");
	end

	rvalid_owned: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		ltc_rvalid |-> outstanding != '0)
	else begin
		fail_count++;
		$error("read data came back with no read in flight");
	end

	// with the FIFO full a read has to wait, anything else may still pass
	overflow_held: assert property (@(posedge clkrst_mem_clk) disable iff (!clkrst_mem_rst_n)
		(|(cli_valid & grant_mask)) && ltc_has_rdata(ltc_opcode) && outstanding == depth_max
		|-> !ltc_valid && (|(cli_stall & grant_mask)))
	else begin
		fail_count++;
		$error("a read was let through with the read FIFO full");
	end

endmodule

bind mem_arb mem_tb_chk u_chk (
	.clkrst_mem_clk  (clkrst_mem_clk),
	.clkrst_mem_rst_n(clkrst_mem_rst_n),
	.cli_valid       (cli_valid),
	.cli_stall       (cli_stall),
	.cur_client      (cur_client),
	.ltc_valid       (ltc_valid),
	.ltc_opcode      (ltc_opcode),
	.ltc_stall       (ltc_stall),
	.ltc_rvalid      (ltc_rvalid)
);
